// File: source/avr_io_pkg.sv
// ******************************
// Bus widths of the CPU side
// ******************************

package avr_io_pkg;

   localparam int io_adr_w = 6;   // I/O space address
   localparam int dm_adr_w = 8;   // Data memory address, low byte
   localparam int data_w   = 8;

   // ******************************
   // Register addresses
   // ******************************

   // External interrupt controller
   localparam logic [dm_adr_w-1:0] eimsk_adr = 8'h39;
   localparam logic [dm_adr_w-1:0] eifr_adr  = 8'h38;
   localparam logic [dm_adr_w-1:0] eicrb_adr = 8'h3A;

   // Lives in data memory only, above the I/O window
   localparam logic [dm_adr_w-1:0] eicra_adr = 8'h6A;

   // Parallel port A
   localparam logic [dm_adr_w-1:0] porta_adr = 8'h1B;
   localparam logic [dm_adr_w-1:0] ddra_adr  = 8'h1A;
   localparam logic [dm_adr_w-1:0] pina_adr  = 8'h19;   // Read only

endpackage

// File: source/ext_int_pkg.sv
// ******************************
// External interrupt encodings
// ******************************

package ext_int_pkg;

   localparam int int_num = 8;   // INT0 .. INT7

   // Two bits per pin in EICRA / EICRB
   typedef enum logic [1:0]
   {
      sense_low  = 2'b00,   // Level, asserted while low
      sense_any  = 2'b01,
      sense_fall = 2'b10,
      sense_rise = 2'b11
   } sense_t;

endpackage

// File: source/rsnc_vect.sv
module rsnc_vect
#(
   parameter int width = 8,
   parameter int stgs  = 2
)
(
   input  logic             cp2,
   input  logic             rst,
   input  logic [width-1:0] di,
   output logic [width-1:0] dout
);

   // Stage 0 may go metastable, later stages settle it
   logic [width-1:0] stg_rg [stgs];

   always_ff @(posedge cp2)
   begin
      if (rst)
      begin
         for (int i = 0; i < stgs; i++)
            stg_rg[i] <= '0;
      end
      else
      begin
         stg_rg[0] <= di;
         for (int i = 1; i < stgs; i++)
            stg_rg[i] <= stg_rg[i-1];   // Shift along the chain
      end
   end

   assign dout = stg_rg[stgs-1];

endmodule

// File: source/ext_int_sense.sv
module ext_int_sense
(
   input  logic                            cp2,
   input  logic                            rst,
   input  logic [ext_int_pkg::int_num-1:0] pin_sync,
   input  logic [7:0]                      eicra,
   input  logic [7:0]                      eicrb,
   output logic [ext_int_pkg::int_num-1:0] set_req
);

   logic [ext_int_pkg::int_num-1:0] pin_del;   // Synchronized pins, one cycle old

   always_ff @(posedge cp2)
   begin
      if (rst)
         pin_del <= '0;
      else
         pin_del <= pin_sync;
   end

   // ******************************
   // Per pin sense decode
   // ******************************

   for (genvar i = 0; i < ext_int_pkg::int_num; i++)
   begin : g_pin
      ext_int_pkg::sense_t mode;

      // Pins 0..3 from EICRA, 4..7 from EICRB
      assign mode = (i < 4) ? ext_int_pkg::sense_t'(eicra[2*(i%4) +: 2])
                            : ext_int_pkg::sense_t'(eicrb[2*(i%4) +: 2]);

      always_comb
      begin
         case (mode)
            ext_int_pkg::sense_low  : set_req[i] = !pin_sync[i];
            ext_int_pkg::sense_any  : set_req[i] = pin_sync[i] ^ pin_del[i];
            ext_int_pkg::sense_fall : set_req[i] = !pin_sync[i] & pin_del[i];
            ext_int_pkg::sense_rise : set_req[i] = pin_sync[i] & !pin_del[i];
            default                 : set_req[i] = 1'b0;
         endcase
      end
   end

endmodule

// File: source/ext_int_mod.sv
module ext_int_mod
#(
   parameter logic [avr_io_pkg::dm_adr_w-1:0] eimsk_adr = avr_io_pkg::eimsk_adr,
   parameter logic [avr_io_pkg::dm_adr_w-1:0] eifr_adr  = avr_io_pkg::eifr_adr,
   parameter logic [avr_io_pkg::dm_adr_w-1:0] eicra_adr = avr_io_pkg::eicra_adr,
   parameter logic [avr_io_pkg::dm_adr_w-1:0] eicrb_adr = avr_io_pkg::eicrb_adr,
   parameter bit                              eimsk_dm_loc = 1'b0,
   parameter bit                              eifr_dm_loc  = 1'b0,
   parameter bit                              eicra_dm_loc = 1'b1,
   parameter bit                              eicrb_dm_loc = 1'b0,
   parameter int                              rsnc_stgs    = 2
)
(
   input  logic                             cp2,
   input  logic                             rst,
   // I/O bus
   input  logic [avr_io_pkg::io_adr_w-1:0]  adr,
   input  logic                             iowe,
   input  logic                             iore,
   input  logic [avr_io_pkg::data_w-1:0]    dbus_in,
   output logic [avr_io_pkg::data_w-1:0]    dbus_out,
   output logic                             io_out_en,
   // Data memory bus
   input  logic [avr_io_pkg::dm_adr_w-1:0]  ramadr,
   input  logic                             ramre,
   input  logic                             ramwe,
   input  logic                             dm_sel,
   input  logic [avr_io_pkg::data_w-1:0]    dm_dbus_in,
   output logic [avr_io_pkg::data_w-1:0]    dm_dbus_out,
   output logic                             dm_out_en,
   // Interrupt pins and CPU side
   input  logic [ext_int_pkg::int_num-1:0]  e_int_in,
   output logic [ext_int_pkg::int_num-1:0]  irq,
   input  logic [ext_int_pkg::int_num-1:0]  irq_ack
);

   localparam int aw = avr_io_pkg::io_adr_w;
   localparam int dw = avr_io_pkg::data_w;

   // Register order in the select vectors: EICRA, EICRB, EIMSK, EIFR
   logic [3:0]    sel_io, sel_dm, we;
   logic          dm_we, dm_re;
   logic [dw-1:0] eicra_rg, eicrb_rg, eimsk_rg, eifr_rg, eifr_nxt;
   logic [dw-1:0] wd_eicra, wd_eicrb, wd_eimsk, wd_eifr;
   logic [ext_int_pkg::int_num-1:0] pin_sync, set_req;

   rsnc_vect #(.width(ext_int_pkg::int_num), .stgs(rsnc_stgs)) u_pin_rsnc
   (
      .cp2  (cp2),
      .rst  (rst),
      .di   (e_int_in),
      .dout (pin_sync)
   );

   ext_int_sense u_sense
   (
      .cp2      (cp2),
      .rst      (rst),
      .pin_sync (pin_sync),
      .eicra    (eicra_rg),
      .eicrb    (eicrb_rg),
      .set_req  (set_req)
   );

   // ******************************
   // Address decode
   // ******************************

   assign dm_we = dm_sel & ramwe;
   assign dm_re = dm_sel & ramre;

   assign sel_io[0] = !eicra_dm_loc & (adr == eicra_adr[aw-1:0]);
   assign sel_io[1] = !eicrb_dm_loc & (adr == eicrb_adr[aw-1:0]);
   assign sel_io[2] = !eimsk_dm_loc & (adr == eimsk_adr[aw-1:0]);
   assign sel_io[3] = !eifr_dm_loc  & (adr == eifr_adr[aw-1:0]);

   assign sel_dm[0] = eicra_dm_loc & (ramadr == eicra_adr);
   assign sel_dm[1] = eicrb_dm_loc & (ramadr == eicrb_adr);
   assign sel_dm[2] = eimsk_dm_loc & (ramadr == eimsk_adr);
   assign sel_dm[3] = eifr_dm_loc  & (ramadr == eifr_adr);

   assign we = (sel_io & {4{iowe}}) | (sel_dm & {4{dm_we}});

   assign wd_eicra = eicra_dm_loc ? dm_dbus_in : dbus_in;
   assign wd_eicrb = eicrb_dm_loc ? dm_dbus_in : dbus_in;
   assign wd_eimsk = eimsk_dm_loc ? dm_dbus_in : dbus_in;
   assign wd_eifr  = eifr_dm_loc  ? dm_dbus_in : dbus_in;

   // ******************************
   // Registers
   // ******************************

   // A flag being cleared this cycle does not pick up set_req
   always_comb
   begin
      eifr_nxt = eifr_rg;
      for (int i = 0; i < ext_int_pkg::int_num; i++)
         if (eifr_rg[i])
            eifr_nxt[i] = !((we[3] & wd_eifr[i]) | irq_ack[i]);   // Write 1 or ack
         else
            eifr_nxt[i] = set_req[i];
   end

   always_ff @(posedge cp2)
   begin
      if (rst)
      begin
         eicra_rg <= '0;
         eicrb_rg <= '0;
         eimsk_rg <= '0;
         eifr_rg  <= '0;
      end
      else
      begin
         if (we[0])
            eicra_rg <= wd_eicra;
         if (we[1])
            eicrb_rg <= wd_eicrb;
         if (we[2])
            eimsk_rg <= wd_eimsk;
         eifr_rg <= eifr_nxt;
      end
   end

   // Read side, each space only sees its own registers
   assign dbus_out = ({dw{sel_io[0]}} & eicra_rg) | ({dw{sel_io[1]}} & eicrb_rg) |
                     ({dw{sel_io[2]}} & eimsk_rg) | ({dw{sel_io[3]}} & eifr_rg);

   assign dm_dbus_out = ({dw{sel_dm[0]}} & eicra_rg) | ({dw{sel_dm[1]}} & eicrb_rg) |
                        ({dw{sel_dm[2]}} & eimsk_rg) | ({dw{sel_dm[3]}} & eifr_rg);

   assign io_out_en = iore & (|sel_io);
   assign dm_out_en = dm_re & (|sel_dm);

   assign irq = eifr_rg[ext_int_pkg::int_num-1:0] & eimsk_rg[ext_int_pkg::int_num-1:0];

endmodule

// File: source/pport.sv
module pport
#(
   parameter logic [avr_io_pkg::dm_adr_w-1:0] port_adr  = avr_io_pkg::porta_adr,
   parameter logic [avr_io_pkg::dm_adr_w-1:0] ddr_adr   = avr_io_pkg::ddra_adr,
   parameter logic [avr_io_pkg::dm_adr_w-1:0] pin_adr   = avr_io_pkg::pina_adr,
   parameter int                              width     = 8,
   parameter int                              rsnc_stgs = 2
)
(
   input  logic                            cp2,
   input  logic                            rst,
   // I/O bus
   input  logic [avr_io_pkg::io_adr_w-1:0] adr,
   input  logic                            iowe,
   input  logic                            iore,
   input  logic [avr_io_pkg::data_w-1:0]   dbus_in,
   output logic [avr_io_pkg::data_w-1:0]   dbus_out,
   output logic                            io_out_en,
   // Pad side
   input  logic [width-1:0]                pin_in,
   output logic [width-1:0]                port_out,
   output logic [width-1:0]                port_oe
);

   localparam int aw = avr_io_pkg::io_adr_w;

   logic [width-1:0] port_rg, ddr_rg, pin_sync;
   logic             sel_port, sel_ddr, sel_pin;

   rsnc_vect #(.width(width), .stgs(rsnc_stgs)) u_pin_rsnc
   (
      .cp2  (cp2),
      .rst  (rst),
      .di   (pin_in),
      .dout (pin_sync)
   );

   assign sel_port = (adr == port_adr[aw-1:0]);
   assign sel_ddr  = (adr == ddr_adr[aw-1:0]);
   assign sel_pin  = (adr == pin_adr[aw-1:0]);   // No write path

   always_ff @(posedge cp2)
   begin
      if (rst)
      begin
         port_rg <= '0;
         ddr_rg  <= '0;
      end
      else
      begin
         if (iowe & sel_port)
            port_rg <= dbus_in[width-1:0];
         if (iowe & sel_ddr)
            ddr_rg <= dbus_in[width-1:0];
      end
   end

   // ******************************
   // Read back
   // ******************************

   always_comb
   begin
      dbus_out = '0;
      if (sel_port)
         dbus_out[width-1:0] = port_rg;
      else if (sel_ddr)
         dbus_out[width-1:0] = ddr_rg;
      else if (sel_pin)
         dbus_out[width-1:0] = pin_sync;   // Two edges behind the pads
   end

   assign io_out_en = iore & (sel_port | sel_ddr | sel_pin);

   assign port_out = port_rg;
   assign port_oe  = ddr_rg;   // A 1 in DDR drives the pad

endmodule

// File: source/avr_periph_top.sv
module avr_periph_top
#(
   parameter int rsnc_stgs = 2
)
(
   input  logic                            cp2,
   input  logic                            rst,
   // I/O bus
   input  logic [avr_io_pkg::io_adr_w-1:0] adr,
   input  logic                            iowe,
   input  logic                            iore,
   input  logic [avr_io_pkg::data_w-1:0]   dbus_in,
   output logic [avr_io_pkg::data_w-1:0]   dbus_out,
   output logic                            io_out_en,
   // Data memory bus
   input  logic [avr_io_pkg::dm_adr_w-1:0] ramadr,
   input  logic                            ramre,
   input  logic                            ramwe,
   input  logic                            dm_sel,
   input  logic [avr_io_pkg::data_w-1:0]   dm_dbus_in,
   output logic [avr_io_pkg::data_w-1:0]   dm_dbus_out,
   output logic                            dm_out_en,
   // External interrupts
   input  logic [7:0]                      e_int_in,
   output logic [7:0]                      irq,
   input  logic [7:0]                      irq_ack,
   // Port A pads
   input  logic [avr_io_pkg::data_w-1:0]   pin_in,
   output logic [avr_io_pkg::data_w-1:0]   port_out,
   output logic [avr_io_pkg::data_w-1:0]   port_oe
);

   localparam int dw = avr_io_pkg::data_w;

   logic [dw-1:0] ei_dbus_out, pa_dbus_out;
   logic          ei_io_out_en, pa_io_out_en;

   // ******************************
   // Interrupt controller
   // ******************************

   ext_int_mod
   #(
      .eimsk_adr    (avr_io_pkg::eimsk_adr),
      .eifr_adr     (avr_io_pkg::eifr_adr),
      .eicra_adr    (avr_io_pkg::eicra_adr),
      .eicrb_adr    (avr_io_pkg::eicrb_adr),
      .eimsk_dm_loc (1'b0),
      .eifr_dm_loc  (1'b0),
      .eicra_dm_loc (1'b1),   // Out of I/O reach
      .eicrb_dm_loc (1'b0),
      .rsnc_stgs    (rsnc_stgs)
   )
   u_ext_int_mod
   (
      .cp2         (cp2),
      .rst         (rst),
      .adr         (adr),
      .iowe        (iowe),
      .iore        (iore),
      .dbus_in     (dbus_in),
      .dbus_out    (ei_dbus_out),
      .io_out_en   (ei_io_out_en),
      .ramadr      (ramadr),
      .ramre       (ramre),
      .ramwe       (ramwe),
      .dm_sel      (dm_sel),
      .dm_dbus_in  (dm_dbus_in),
      .dm_dbus_out (dm_dbus_out),
      .dm_out_en   (dm_out_en),
      .e_int_in    (e_int_in),
      .irq         (irq),
      .irq_ack     (irq_ack)
   );

   // ******************************
   // Port A
   // ******************************

   pport
   #(
      .port_adr  (avr_io_pkg::porta_adr),
      .ddr_adr   (avr_io_pkg::ddra_adr),
      .pin_adr   (avr_io_pkg::pina_adr),
      .width     (dw),
      .rsnc_stgs (rsnc_stgs)
   )
   u_porta
   (
      .cp2       (cp2),
      .rst       (rst),
      .adr       (adr),
      .iowe      (iowe),
      .iore      (iore),
      .dbus_in   (dbus_in),
      .dbus_out  (pa_dbus_out),
      .io_out_en (pa_io_out_en),
      .pin_in    (pin_in),
      .port_out  (port_out),
      .port_oe   (port_oe)
   );

   // Read merge, a peripheral only contributes while it owns the cycle
   assign dbus_out  = ({dw{ei_io_out_en}} & ei_dbus_out) | ({dw{pa_io_out_en}} & pa_dbus_out);
   assign io_out_en = ei_io_out_en | pa_io_out_en;

endmodule

// File: tb/ext_int_chk.sv
module ext_int_chk
(
   input logic       cp2,
   input logic       rst,
   input logic       io_out_en,
   input logic       dm_out_en,
   input logic [7:0] irq,
   input logic [7:0] irq_ack,
   input logic [7:0] eifr,
   input logic [7:0] set_req
);

   // An acknowledged interrupt is gone one edge later
   a_ack_clears : assert property (@(posedge cp2) disable iff (rst)
      (irq & $past(irq_ack & irq)) == 8'h00)
      else $error("irq still high one cycle after irq_ack");

   a_flag_src : assert property (@(posedge cp2) disable iff (rst)
      (eifr & ~$past(eifr) & ~$past(set_req)) == 8'h00)   // Flags rise only on a request
      else $error("EIFR flag set without a sense request");

   // Never both read buses in one cycle
   a_one_bus : assert property (@(posedge cp2) disable iff (rst) !(io_out_en && dm_out_en))
      else $error("io_out_en and dm_out_en high together");

endmodule

bind ext_int_mod ext_int_chk u_ext_int_chk
(
   .cp2       (cp2),
   .rst       (rst),
   .io_out_en (io_out_en),
   .dm_out_en (dm_out_en),
   .irq       (irq),
   .irq_ack   (irq_ack),
   .eifr      (eifr_rg),
   .set_req   (set_req)
);

// File: tb/avr_periph_tb.sv
module avr_periph_tb;

   localparam int clk_per = 100;

   logic                            cp2, rst;
   logic [avr_io_pkg::io_adr_w-1:0] adr;
   logic                            iowe, iore, io_out_en;
   logic [7:0]                      dbus_in, dbus_out;
   logic [7:0]                      ramadr, dm_dbus_in, dm_dbus_out;
   logic                            ramre, ramwe, dm_sel, dm_out_en;
   logic [ext_int_pkg::int_num-1:0] e_int_in, irq, irq_ack;
   logic [7:0]                      pin_in, port_out, port_oe;

   int err_cnt  = 0;
   int test_cnt = 0;
   int wd_time  = 0;   // Set once the patterns are counted

   avr_periph_top u_avr_periph_top (.*);

   initial
      cp2 = 1'b0;

   always
      #(clk_per / 2) cp2 = ~cp2;

   // ******************************
   // Bus operations
   // ******************************

   task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act)
      begin
         $display("ERR %s expected %02h got %02h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic io_write(input logic [7:0] a, input logic [7:0] d);
      @(posedge cp2);
      adr     <= a[5:0];
      dbus_in <= d;
      iowe    <= 1'b1;
      @(posedge cp2);
      iowe <= 1'b0;   // Register took the data at this edge
   endtask

   task automatic dm_write(input logic [7:0] a, input logic [7:0] d);
      @(posedge cp2);
      ramadr     <= a;
      dm_dbus_in <= d;
      dm_sel     <= 1'b1;
      ramwe      <= 1'b1;
      @(posedge cp2);
      dm_sel <= 1'b0;
      ramwe  <= 1'b0;
   endtask

   task automatic io_read(input string name, input logic [7:0] a, input logic [7:0] exp,
                          input logic [7:0] exp_en);
      @(posedge cp2);
      adr  <= a[5:0];
      iore <= 1'b1;
      @(negedge cp2);   // Combinational read, settled mid cycle
      check_val({name, " data"}, exp, dbus_out);
      check_val({name, " io_out_en"}, exp_en, {7'b0, io_out_en});
      @(posedge cp2);
      iore <= 1'b0;
   endtask

   task automatic dm_read(input string name, input logic [7:0] a, input logic [7:0] exp,
                          input logic [7:0] exp_en);
      @(posedge cp2);
      ramadr <= a;
      dm_sel <= 1'b1;
      ramre  <= 1'b1;
      @(negedge cp2);
      check_val({name, " data"}, exp, dm_dbus_out);
      check_val({name, " dm_out_en"}, exp_en, {7'b0, dm_out_en});
      @(posedge cp2);
      dm_sel <= 1'b0;
      ramre  <= 1'b0;
   endtask

   // ******************************
   // One pattern line
   // ******************************

   task automatic run_op(input string op, input string name,
                         input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
      int          err_start;
      logic [31:0] rnd;
      err_start = err_cnt;
      case (op)
         "iow" : io_write(a, b);
         "dmw" : dm_write(a, b);
         "ior" : io_read(name, a, b, c);
         "dmr" : dm_read(name, a, b, c);
         "fcw" :
         begin
            // Bits outside both masks belong to flags known to be clear
            rnd = $urandom;
            io_write(avr_io_pkg::eifr_adr, a | (rnd[7:0] & ~(a | b)));
         end
         "pins" :
         begin
            @(posedge cp2);
            e_int_in <= a;
            pin_in   <= b;
         end
         "ack" :
         begin
            @(posedge cp2);
            irq_ack <= a;
            @(posedge cp2);
            irq_ack <= '0;
         end
         "wait" : repeat (a) @(posedge cp2);
         "irq" :
         begin
            @(negedge cp2);
            check_val({name, " irq"}, a, irq);
         end
         "port" :
         begin
            @(negedge cp2);
            check_val({name, " port_out"}, a, port_out);
            check_val({name, " port_oe"}, b, port_oe);
         end
         default :
         begin
            $display("%s: unknown operation %s in the pattern file", name, op);
            err_cnt++;
         end
      endcase
      test_cnt++;
      if (err_cnt == err_start)
         $display("%s ok", name);
      else
         $display("%s failed", name);
   endtask

   initial
   begin
      int          fd, code;
      string       lines[$];
      string       line, op, name;
      logic [31:0] fa, fb, fc, seed;

      seed       = $urandom(32'hbbdc_6129);
      rst        = 1'b1;
      adr        = '0;
      iowe       = 1'b0;
      iore       = 1'b0;
      dbus_in    = '0;
      ramadr     = '0;
      ramre      = 1'b0;
      ramwe      = 1'b0;
      dm_sel     = 1'b0;
      dm_dbus_in = '0;
      e_int_in   = 8'hff;   // Pads idle high
      irq_ack    = '0;
      pin_in     = '0;

      fd = $fopen("tb/avr_periph_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("pattern file tb/avr_periph_patterns.txt could not be opened");
         $display("Done: errors found");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            if (code > 0)
               lines.push_back(line);
         end
         $fclose(fd);
         wd_time = (lines.size() * 20 + 100) * clk_per;

         repeat (5) @(posedge cp2);
         rst <= 1'b0;

         foreach (lines[i])
         begin
            // Skip blank lines and lines opening with '#'
            if (lines[i].len() > 1 && lines[i].getc(0) != 8'h23)
            begin
               code = $sscanf(lines[i], "%s %s %h %h %h", op, name, fa, fb, fc);
               if (code == 5)
                  run_op(op, name, fa[7:0], fb[7:0], fc[7:0]);
               else
               begin
                  $display("pattern line %0d could not be parsed", i + 1);
                  err_cnt++;
               end
            end
         end

         $display("%0d tests, %0d errors", test_cnt, err_cnt);
         if (err_cnt == 0)
            $display("Done: no errors");
         else
            $display("Done: errors found");
         $finish;
      end
   end

   // Watchdog
   initial
   begin
      wait (wd_time > 0);
      #(wd_time);
      $display("timeout, patterns not finished");
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: avr_periph_top.f
source/avr_io_pkg.sv
source/ext_int_pkg.sv
source/rsnc_vect.sv
source/ext_int_sense.sv
source/ext_int_mod.sv
source/pport.sv
source/avr_periph_top.sv
tb/ext_int_chk.sv
tb/avr_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module avr_periph_tb -f avr_periph_top.f -o avr_periph_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/avr_periph_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
   exit 0
fi
echo "pass line missing from simulation output"
exit 1

// File: tb/avr_periph_patterns.txt
# op name a b c, fields in hex. iow/dmw: adr data. ior/dmr: adr exp_data exp_en
# fcw: ones zeros. pins: e_int pin_in. ack: mask. wait: cycles. irq: exp. port: out oe
wait  rst_settle    4  0  0
ior   rst_flags    38 ff  1
fcw   rst_clear    ff 00  0
ior   flags_idle   38 00  1
iow   eimsk_wr     39 a5  0
ior   eimsk_rd     39 a5  1
iow   eicrb_wr     3a 5a  0
ior   eicrb_rd     3a 5a  1
dmw   eicra_wr     6a e4  0
dmr   eicra_rd     6a e4  1
dmr   eimsk_dm     39 00  0
ior   unowned_rd   2a 00  0
iow   porta_wr     1b 3c  0
iow   ddra_wr      1a c3  0
ior   porta_rd     1b 3c  1
ior   ddra_rd      1a c3  1
port  port_regs    3c c3  0
# Pin 0 low level
pins  low_drive    fe 00  0
wait  low_settle    3  0  0
ior   low_flag     38 01  1
fcw   low_clear    01 00  0
ior   low_again    38 01  1
pins  low_release  ff 00  0
wait  low_settle2   3  0  0
fcw   low_clear2   01 00  0
ior   low_cleared  38 00  1
# Pin 1 any change
pins  any_fall     fd 00  0
wait  any_settle    3  0  0
ior   any_flag     38 02  1
fcw   any_clear    02 00  0
pins  any_rise     ff 00  0
wait  any_settle2   3  0  0
ior   any_flag2    38 02  1
fcw   any_clear2   02 00  0
ior   any_cleared  38 00  1
# Pin 2 falling, pin 3 rising
pins  fall_drive   fb 00  0
wait  fall_settle   3  0  0
ior   fall_flag    38 04  1
fcw   fall_clear   04 00  0
pins  fall_rise    ff 00  0
wait  fall_settle2  3  0  0
ior   fall_no_rise 38 00  1
pins  rise_fall    f7 00  0
wait  rise_settle   3  0  0
ior   rise_no_fall 38 00  1
pins  rise_drive   ff 00  0
wait  rise_settle2  3  0  0
ior   rise_flag    38 08  1
# Masking and clearing
pins  mask_pins    f9 00  0
wait  mask_settle   3  0  0
ior   mask_flags   38 0e  1
iow   mask_one     39 02  0
irq   irq_one      02  0  0
iow   mask_all     39 ff  0
irq   irq_all      0e  0  0
iow   mask_none    39 00  0
irq   irq_none     00  0  0
fcw   write_zero   00 0e  0
ior   zero_kept    38 0e  1
fcw   write_one    04 0a  0
ior   one_cleared  38 0a  1
iow   mask_ack     39 ff  0
ack   ack_pin1     02  0  0
irq   ack_cleared  08  0  0
# Port A
pins  pin_drive    f9 96  0
wait  pin_settle    3  0  0
ior   pina_rd      19 96  1
pins  pin_change   f9 69  0
ior   pin_lag      19 96  1
wait  pin_settle2   2  0  0
ior   pina_rd2     19 69  1
iow   porta_wr2    1b 5a  0
iow   ddra_wr2     1a 0f  0
port  port_regs2   5a 0f  0
